/* logic/rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data and address width
`define RV_XLEN 32

// integer register file
`define RV_NUM_REGS 32
`define RV_REG_AW 5

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0100

`endif

/* logic/rv_pkg.sv */
`default_nettype none

`include "rv_settings.svh"

package rv_pkg;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    // immediate bits overlap funct7 and rs2
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_u;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [`RV_XLEN-1:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic                ack;
        logic [`RV_XLEN-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        inst_u               inst;
    } fetch_t;

    typedef struct packed {
        logic                  valid;
        logic [`RV_XLEN-1:0]   pc;
        alu_op_e               alu_op;
        logic [`RV_REG_AW-1:0] rd;
        logic                  writes_rd;
        logic                  use_imm;
        logic                  is_branch;
        logic                  branch_ne;
        logic                  is_jal;
        logic [`RV_XLEN-1:0]   rs1_val;
        logic [`RV_XLEN-1:0]   rs2_val;
        logic [`RV_XLEN-1:0]   imm;
    } dec_t;

    // valid only for a real write to a nonzero rd
    typedef struct packed {
        logic                  valid;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   value;
    } exe_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                  valid;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   value;
    } retire_t;

endpackage

`default_nettype wire

/* logic/rv_fetch.sv */
`default_nettype none
`timescale 1ns/100ps

`include "rv_settings.svh"

module rv_fetch
    import rv_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire redirect_t redirect,
    output wb_req_t        ibus_req,
    input  wire wb_rsp_t   ibus_rsp,
    output fetch_t         fetched
);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] next_pc;
    // open read belongs to a flushed path
    logic                stale;

    assign next_pc = redirect.valid ? redirect.target : pc;

    always_ff @(posedge clk) begin
        // address and word of the current bus read
        fetched.pc   <= ibus_req.adr;
        fetched.inst <= ibus_rsp.dat;

        if (!rst_n) begin
            ibus_req      <= '0;
            pc            <= `RV_RESET_PC;
            stale         <= 1'b0;
            fetched.valid <= 1'b0;
        end else begin
            fetched.valid <= 1'b0;

            if (!ibus_req.stb) begin
                // bus idle, open the next read
                ibus_req.cyc <= 1'b1;
                ibus_req.stb <= 1'b1;
                ibus_req.we  <= 1'b0;
                ibus_req.adr <= next_pc;
                pc           <= next_pc;
            end else if (ibus_rsp.ack) begin
                ibus_req.cyc <= 1'b0;
                ibus_req.stb <= 1'b0;
                stale        <= 1'b0;
                if (stale || redirect.valid) begin
                    // drop the word, restart at the target
                    pc <= next_pc;
                end else begin
                    fetched.valid <= 1'b1;
                    pc            <= ibus_req.adr + `RV_XLEN'(4);
                end
            end else if (redirect.valid) begin
                // read must still finish on the bus
                stale <= 1'b1;
                pc    <= redirect.target;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/rv_decode.sv */
`default_nettype none
`timescale 1ns/100ps

`include "rv_settings.svh"

module rv_decode
    import rv_pkg::*;
(
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire fetch_t                fetched,
    input  wire redirect_t             redirect,
    output logic [`RV_REG_AW-1:0]      rs1_idx,
    output logic [`RV_REG_AW-1:0]      rs2_idx,
    input  wire  [`RV_XLEN-1:0]        rs1_rdata,
    input  wire  [`RV_XLEN-1:0]        rs2_rdata,
    input  wire exe_t                  ex_fwd,
    input  wire exe_t                  ex_out,
    output dec_t                       decoded
);

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    inst_u               w;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_j;
    logic [`RV_XLEN-1:0] imm_u;
    dec_t                dec_next;

    // youngest producer wins
    function automatic logic [`RV_XLEN-1:0] fwd_pick(
        input logic [`RV_REG_AW-1:0] idx,
        input logic [`RV_XLEN-1:0]   rf_val,
        input exe_t                  near,
        input exe_t                  far
    );
        if (near.valid && near.rd == idx) begin
            return near.value;
        end else if (far.valid && far.rd == idx) begin
            return far.value;
        end
        return rf_val;
    endfunction

    assign w       = fetched.inst;
    assign rs1_idx = w.r.rs1;
    assign rs2_idx = w.r.rs2;

    assign imm_i = {{20{w.i.imm[11]}}, w.i.imm};
    assign imm_b = {{20{w.r.funct7[6]}}, w.r.rd[0], w.r.funct7[5:0], w.r.rd[4:1], 1'b0};
    assign imm_j = {{12{w.i.imm[11]}}, w.i.rs1, w.i.funct3, w.i.imm[0], w.i.imm[10:1], 1'b0};
    assign imm_u = {w.i.imm, w.i.rs1, w.i.funct3, 12'b0};

    always_comb begin
        dec_next.valid     = fetched.valid && !redirect.valid;
        dec_next.pc        = fetched.pc;
        dec_next.rd        = w.r.rd;
        dec_next.alu_op    = alu_add;
        dec_next.writes_rd = 1'b0;
        dec_next.use_imm   = 1'b0;
        dec_next.is_branch = 1'b0;
        dec_next.branch_ne = 1'b0;
        dec_next.is_jal    = 1'b0;
        dec_next.imm       = imm_i;
        dec_next.rs1_val   = fwd_pick(w.r.rs1, rs1_rdata, ex_fwd, ex_out);
        dec_next.rs2_val   = fwd_pick(w.r.rs2, rs2_rdata, ex_fwd, ex_out);

        case (w.r.opcode)
            opc_op: begin
                dec_next.writes_rd = 1'b1;
                case ({w.r.funct7, w.r.funct3})
                    {7'h00, 3'b000}: dec_next.alu_op = alu_add;
                    {7'h20, 3'b000}: dec_next.alu_op = alu_sub;
                    {7'h00, 3'b111}: dec_next.alu_op = alu_and;
                    {7'h00, 3'b110}: dec_next.alu_op = alu_or;
                    {7'h00, 3'b100}: dec_next.alu_op = alu_xor;
                    {7'h00, 3'b010}: dec_next.alu_op = alu_slt;
                    default:         dec_next.writes_rd = 1'b0;
                endcase
            end
            opc_op_imm: begin
                dec_next.writes_rd = 1'b1;
                dec_next.use_imm   = 1'b1;
                case (w.i.funct3)
                    3'b000:  dec_next.alu_op = alu_add;
                    3'b111:  dec_next.alu_op = alu_and;
                    3'b110:  dec_next.alu_op = alu_or;
                    3'b100:  dec_next.alu_op = alu_xor;
                    default: dec_next.writes_rd = 1'b0;
                endcase
            end
            opc_lui: begin
                dec_next.writes_rd = 1'b1;
                dec_next.use_imm   = 1'b1;
                dec_next.alu_op    = alu_pass_b;
                dec_next.imm       = imm_u;
            end
            opc_branch: begin
                // only beq and bne
                dec_next.imm       = imm_b;
                dec_next.is_branch = (w.r.funct3[2:1] == 2'b00);
                dec_next.branch_ne = w.r.funct3[0];
            end
            opc_jal: begin
                dec_next.writes_rd = 1'b1;
                dec_next.is_jal    = 1'b1;
                dec_next.imm       = imm_j;
            end
            default: begin
                dec_next.writes_rd = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        decoded <= dec_next;
        if (!rst_n) begin
            decoded.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/rv_execute.sv */
`default_nettype none
`timescale 1ns/100ps

`include "rv_settings.svh"

module rv_execute
    import rv_pkg::*;
(
    input  wire       clk,
    input  wire       rst_n,
    input  wire dec_t decoded,
    output exe_t      ex_fwd,
    output exe_t      ex_out,
    output redirect_t redirect
);

    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_res;
    logic                taken;

    always_comb begin
        op_b = decoded.use_imm ? decoded.imm : decoded.rs2_val;

        case (decoded.alu_op)
            alu_add: alu_res = decoded.rs1_val + op_b;
            alu_sub: alu_res = decoded.rs1_val - op_b;
            alu_and: alu_res = decoded.rs1_val & op_b;
            alu_or:  alu_res = decoded.rs1_val | op_b;
            alu_xor: alu_res = decoded.rs1_val ^ op_b;
            alu_slt: begin
                alu_res = {{(`RV_XLEN-1){1'b0}},
                           $signed(decoded.rs1_val) < $signed(op_b)};
            end
            default: alu_res = op_b;
        endcase
    end

    // beq taken on equal, bne on not equal
    assign taken = decoded.is_branch &&
                   ((decoded.rs1_val == decoded.rs2_val) != decoded.branch_ne);

    assign redirect.valid  = decoded.valid && (taken || decoded.is_jal);
    assign redirect.target = decoded.pc + decoded.imm;

    assign ex_fwd.valid = decoded.valid && decoded.writes_rd && (decoded.rd != '0);
    assign ex_fwd.rd    = decoded.rd;
    // link value for jal
    assign ex_fwd.value = decoded.is_jal ? decoded.pc + `RV_XLEN'(4) : alu_res;

    always_ff @(posedge clk) begin
        ex_out.rd    <= ex_fwd.rd;
        ex_out.value <= ex_fwd.value;
        if (!rst_n) begin
            ex_out.valid <= 1'b0;
        end else begin
            ex_out.valid <= ex_fwd.valid;
        end
    end

endmodule

`default_nettype wire

/* logic/rv_result.sv */
`default_nettype none
`timescale 1ns/100ps

`include "rv_settings.svh"

module rv_result
    import rv_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire exe_t             ex_out,
    input  wire [`RV_REG_AW-1:0]  rs1_idx,
    input  wire [`RV_REG_AW-1:0]  rs2_idx,
    output logic [`RV_XLEN-1:0]   rs1_rdata,
    output logic [`RV_XLEN-1:0]   rs2_rdata,
    output retire_t               retire
);

    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

    // x0 is hardwired
    assign rs1_rdata = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_rdata = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    always_ff @(posedge clk) begin
        if (ex_out.valid) begin
            regs[ex_out.rd] <= ex_out.value;
        end
    end

    // same write, one cycle later
    always_ff @(posedge clk) begin
        retire.rd    <= ex_out.rd;
        retire.value <= ex_out.value;
        if (!rst_n) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= ex_out.valid;
        end
    end

endmodule

`default_nettype wire

/* logic/rv_core.sv */
`default_nettype none
`timescale 1ns/100ps

`include "rv_settings.svh"

module rv_core
    import rv_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    output wb_req_t      ibus_req,
    input  wire wb_rsp_t ibus_rsp,
    output retire_t      retire
);

    fetch_t                fetched;
    dec_t                  decoded;
    exe_t                  ex_fwd;
    exe_t                  ex_out;
    redirect_t             redirect;
    logic [`RV_REG_AW-1:0] rs1_idx;
    logic [`RV_REG_AW-1:0] rs2_idx;
    logic [`RV_XLEN-1:0]   rs1_rdata;
    logic [`RV_XLEN-1:0]   rs2_rdata;

    rv_fetch fetch_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .redirect (redirect),
        .ibus_req (ibus_req),
        .ibus_rsp (ibus_rsp),
        .fetched  (fetched)
    );

    rv_decode decode_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetched   (fetched),
        .redirect  (redirect),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .rs1_rdata (rs1_rdata),
        .rs2_rdata (rs2_rdata),
        .ex_fwd    (ex_fwd),
        .ex_out    (ex_out),
        .decoded   (decoded)
    );

    rv_execute execute_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .decoded  (decoded),
        .ex_fwd   (ex_fwd),
        .ex_out   (ex_out),
        .redirect (redirect)
    );

    rv_result result_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_out    (ex_out),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .rs1_rdata (rs1_rdata),
        .rs2_rdata (rs2_rdata),
        .retire    (retire)
    );

endmodule

`default_nettype wire

/* testbench/rv_core_assertions.sv */
`default_nettype none
`timescale 1ns/100ps

module rv_core_assertions
    import rv_pkg::*;
(
    input wire          clk,
    input wire          rst_n,
    input wire wb_req_t ibus_req,
    input wire wb_rsp_t ibus_rsp,
    input wire retire_t retire
);

    // wishbone classic read rules
    stb_has_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        ibus_req.stb |-> ibus_req.cyc)
        else $error("stb raised without cyc");

    req_held_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (ibus_req.stb && !ibus_rsp.ack) |=> (ibus_req.stb && $stable(ibus_req.adr)))
        else $error("request changed before ack");

    adr_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        ibus_req.stb |-> (ibus_req.adr[1:0] == 2'b00))
        else $error("fetch address not word aligned");

    // quiet outputs under reset
    no_cyc_in_reset: assert property (@(posedge clk)
        !rst_n |=> !ibus_req.cyc)
        else $error("cyc seen during reset");

    no_retire_in_reset: assert property (@(posedge clk)
        !rst_n |=> !retire.valid)
        else $error("retire valid during reset");

endmodule

bind rv_core rv_core_assertions assertions_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .ibus_req (ibus_req),
    .ibus_rsp (ibus_rsp),
    .retire   (retire)
);

`default_nettype wire

/* testbench/rv_core_tb.sv */
`default_nettype none
`timescale 1ns/100ps

`include "rv_settings.svh"

module rv_core_tb
    import rv_pkg::*;
();

    localparam int reset_cycles    = 8;
    localparam int drain_cycles    = 12;
    localparam int num_words       = 27;
    localparam int num_rows        = 16;
    localparam int watchdog_cycles = num_rows * 20 + reset_cycles + drain_cycles;

    typedef struct packed {
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   value;
    } exp_row_t;

    logic    clk = 1'b0;
    logic    rst_n;
    wb_req_t ibus_req;
    wb_rsp_t ibus_rsp;
    retire_t retire;

    logic [`RV_XLEN-1:0] prog [num_words];
    exp_row_t            exp_rows [num_rows];
    integer              seed;
    int                  wait_left;
    logic                busy;
    logic                seen_first;

    rv_core rv_core_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .ibus_req (ibus_req),
        .ibus_rsp (ibus_rsp),
        .retire   (retire)
    );

    always #20 clk = ~clk;

    // rv32i encodings
    function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_word(int imm, int rd);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] branch_word(int off, int rs2, int rs1, int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_word(int off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] adr);
        int          idx;
        logic [11:0] fold;
        idx  = int'((adr - `RV_RESET_PC) >> 2);
        fold = adr[11:0] ^ adr[23:12] ^ {4'h0, adr[31:24]};
        if (adr >= `RV_RESET_PC && idx < num_words) begin
            return prog[idx];
        end
        // unmapped words retire into x31
        return i_type(int'(fold), 0, 0, 31);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is %h, expected %h", name, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_table();
        prog[0]  = i_type(5, 0, 0, 1);
        prog[1]  = i_type(-3, 0, 0, 2);
        prog[2]  = r_type(0, 2, 1, 0, 3);
        prog[3]  = r_type(32, 1, 3, 0, 4);
        prog[4]  = r_type(0, 3, 4, 2, 5);
        prog[5]  = r_type(0, 2, 5, 4, 6);
        prog[6]  = r_type(0, 1, 6, 6, 7);
        prog[7]  = r_type(0, 1, 7, 7, 8);
        prog[8]  = lui_word('h12345, 9);
        prog[9]  = i_type('h678, 9, 6, 10);
        prog[10] = i_type('h0f0, 10, 7, 11);
        prog[11] = i_type(-1, 11, 4, 12);
        // write to x0, then read x0
        prog[12] = i_type(7, 1, 0, 0);
        prog[13] = r_type(0, 1, 0, 0, 13);
        prog[14] = branch_word(12, 8, 1, 0);
        prog[15] = i_type(1, 0, 0, 14);
        prog[16] = i_type(2, 0, 0, 14);
        prog[17] = branch_word(8, 13, 1, 1);
        prog[18] = i_type(9, 0, 0, 15);
        prog[19] = branch_word(8, 1, 15, 1);
        prog[20] = i_type(1, 0, 0, 15);
        prog[21] = jal_word(12, 16);
        prog[22] = i_type(1, 0, 0, 17);
        prog[23] = i_type(2, 0, 0, 17);
        prog[24] = branch_word(8, 2, 1, 0);
        prog[25] = r_type(0, 15, 16, 0, 17);
        prog[26] = jal_word(0, 0);

        exp_rows[0]  = '{5'd1,  32'h0000_0005};
        exp_rows[1]  = '{5'd2,  32'hffff_fffd};
        exp_rows[2]  = '{5'd3,  32'h0000_0002};
        exp_rows[3]  = '{5'd4,  32'hffff_fffd};
        exp_rows[4]  = '{5'd5,  32'h0000_0001};
        exp_rows[5]  = '{5'd6,  32'hffff_fffc};
        exp_rows[6]  = '{5'd7,  32'hffff_fffd};
        exp_rows[7]  = '{5'd8,  32'h0000_0005};
        exp_rows[8]  = '{5'd9,  32'h1234_5000};
        exp_rows[9]  = '{5'd10, 32'h1234_5678};
        exp_rows[10] = '{5'd11, 32'h0000_0070};
        exp_rows[11] = '{5'd12, 32'hffff_ff8f};
        exp_rows[12] = '{5'd13, 32'h0000_0005};
        exp_rows[13] = '{5'd15, 32'h0000_0009};
        // link value of the jal at 0x154
        exp_rows[14] = '{5'd16, 32'h0000_0158};
        exp_rows[15] = '{5'd17, 32'h0000_0161};
    endtask

    // one negedge step of the instruction memory
    task automatic serve_bus();
        if (ibus_rsp.ack) begin
            ibus_rsp.ack = 1'b0;
            busy         = 1'b0;
        end else if (ibus_req.stb) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = $random(seed) & 3;
                // instruction bus only reads
                check_value("ibus_req.we", 32'(ibus_req.we), 32'h0);
                if (!seen_first) begin
                    check_value("ibus_req.adr", ibus_req.adr, `RV_RESET_PC);
                    seen_first = 1'b1;
                end
            end
            if (wait_left == 0) begin
                ibus_rsp.ack = 1'b1;
                ibus_rsp.dat = mem_word(ibus_req.adr);
            end else begin
                wait_left = wait_left - 1;
            end
        end
    endtask

    initial begin
        int row;
        int drain;
        seed       = 16;
        rst_n      = 1'b0;
        ibus_rsp   = '0;
        busy       = 1'b0;
        wait_left  = 0;
        seen_first = 1'b0;
        row        = 0;
        drain      = 0;
        load_table();

        repeat (reset_cycles) begin
            @(negedge clk);
            check_value("ibus_req.cyc", 32'(ibus_req.cyc), 32'h0);
            check_value("retire.valid", 32'(retire.valid), 32'h0);
        end
        rst_n = 1'b1;

        while (drain < drain_cycles) begin
            @(negedge clk);
            if (retire.valid) begin
                if (row >= num_rows) begin
                    $display("unexpected retire to x%0d after the last expected row", retire.rd);
                    $display(">>> FAIL");
                    $fatal(1, "extra retire");
                end else begin
                    check_value("retire.rd", 32'(retire.rd), 32'(exp_rows[row].rd));
                    check_value("retire.value", retire.value, exp_rows[row].value);
                    row = row + 1;
                end
            end
            serve_bus();
            if (row == num_rows) begin
                drain = drain + 1;
            end
        end
        $display(">>> PASS");
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout, retire events stopped before every expected row was seen");
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+logic
logic/rv_pkg.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_result.sv
logic/rv_core.sv
testbench/rv_core_assertions.sv
testbench/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# build the rv_core testbench with Verilator, run it and look for the pass line
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f tb.f --top-module rv_core_tb -o rv_core_sim \
    && ./obj_dir/rv_core_sim | tee sim.log \
    && grep -qx '>>> PASS' sim.log \
    || { echo "rv_core simulation failed"; exit 1; }

echo "rv_core simulation passed"
